/* verilog/exStage_defs.svh */
//----------------------------------------------------------------------
// Widths, register IDs and fixed codes of the EX1 execute stage.
// Include in any file that sizes ports by these macros.
//----------------------------------------------------------------------

`ifndef EX_STAGE_DEFS_SVH
`define EX_STAGE_DEFS_SVH

// Datapath widths
`define EX_GPR_ID_W		6
`define EX_DATA_W		64
`define EX_VADDR_W		48

// Register IDs
`define EX_GR_ZZR		6'h3F		// GPR no-write
`define EX_CR_ZZR		6'h3F		// CR no-write
`define EX_CR_PC		6'h00		// Branch redirect target

// Upper 12 bits of a TRAPA exception code, trap number goes below
`define EX_TRAPA_BASE	12'hC08

// memDataOK value while the memory side is busy
`define EX_HOLD_CODE	2'b10

`endif

/* verilog/exStagePkg.sv */
//----------------------------------------------------------------------
// Enum types shared by the EX1 stage: condition codes, micro-opcodes,
// sub-opcodes for the IXS/IXT groups and memory access kind.
// Reference by scoped names, exStagePkg::name.
//----------------------------------------------------------------------

`default_nettype none

package exStagePkg;

	// Condition field, opUCmd[7:6]
	typedef enum logic [1:0] {
		CC_AL = 2'b00,		// Always
		CC_NV = 2'b01,		// Never
		CC_CT = 2'b10,		// If T set
		CC_CF = 2'b11		// If T clear
	} condCode;

	// Micro-command, opUCmd[5:0]
	typedef enum logic [5:0] {
		UCMD_NOP    = 6'h00,
		UCMD_INVOP  = 6'h01,
		UCMD_LEA_MR = 6'h02,
		UCMD_MOV_RM = 6'h03,	// Store
		UCMD_MOV_MR = 6'h04,	// Load
		UCMD_ALU3   = 6'h05,
		UCMD_MOV_IR = 6'h06,
		UCMD_BRA    = 6'h07,
		UCMD_BRA_NB = 6'h08,	// Not-taken branch
		UCMD_JMP    = 6'h09,
		UCMD_JSR    = 6'h0A,
		UCMD_OP_IXS = 6'h0B,
		UCMD_OP_IXT = 6'h0C
	} uCmd;

	typedef enum logic [5:0] {
		IXS_NOP   = 6'h00,
		IXS_MOVT  = 6'h01,
		IXS_MOVNT = 6'h02,
		IXS_MOVST = 6'h03
	} ixsOp;

	typedef enum logic [5:0] {
		IXT_NOP   = 6'h00,
		IXT_CLRT  = 6'h01,
		IXT_SETT  = 6'h02,
		IXT_CLRS  = 6'h03,
		IXT_SETS  = 6'h04,
		IXT_NOTT  = 6'h05,
		IXT_NOTS  = 6'h06,
		IXT_TRAPA = 6'h07,
		IXT_BREAK = 6'h08
	} ixtOp;

	// Top two bits of memOpm
	typedef enum logic [1:0] {
		MEM_READY = 2'b00,
		MEM_LOAD  = 2'b01,
		MEM_STORE = 2'b10
	} memKind;

endpackage

`default_nettype wire

/* verilog/exCondGate.sv */
//----------------------------------------------------------------------
// Input side of EX1. Tests the condition field against SR.T and the
// branch flush, and rewrites suppressed commands into BRA_NB or NOP.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exCondGate (
	input  logic [7:0]       opUCmd,
	input  logic             opBraFlush,
	input  logic             srT,
	output exStagePkg::uCmd  gatedCmd,
	output logic             squash,
	output logic [7:0]       opUCmdOut
);

	exStagePkg::condCode cc;
	exStagePkg::uCmd rawCmd;
	logic enable;

	assign cc = exStagePkg::condCode'(opUCmd[7:6]);
	assign rawCmd = exStagePkg::uCmd'(opUCmd[5:0]);

	always_comb begin
		case (cc)
			exStagePkg::CC_AL: enable = 1'b1;
			exStagePkg::CC_NV: enable = 1'b0;
			exStagePkg::CC_CT: enable = srT;
			default:           enable = !srT;
		endcase
		if (opBraFlush)
			enable = 1'b0;		// Flushed slot never executes

		if (enable)
			gatedCmd = rawCmd;
		else if ((rawCmd == exStagePkg::UCMD_BRA) && !opBraFlush)
			gatedCmd = exStagePkg::UCMD_BRA_NB;	// Let a not-taken predicted BRA recover
		else
			gatedCmd = exStagePkg::UCMD_NOP;
	end

	assign squash = opBraFlush;
	assign opUCmdOut = {exStagePkg::CC_AL, gatedCmd};	// Later stages see it as unconditional

endmodule

`default_nettype wire

/* verilog/exAgu.sv */
//----------------------------------------------------------------------
// Address unit of EX1. Forms base + (index << scale) and the branch
// target, whose high word comes from the PC unless jumbo mode was set
// in SR bit 31 on the previous cycle.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exAgu (
	input  logic                   clock,
	input  logic                   rst,
	input  logic [`EX_DATA_W-1:0]  regValRs,
	input  logic [`EX_DATA_W-1:0]  regValRt,
	input  logic [1:0]             scale,
	input  logic [`EX_DATA_W-1:0]  regValPc,
	input  logic                   srJumbo,
	output logic [`EX_VADDR_W-1:0] aguAddr,
	output logic [`EX_VADDR_W-1:0] aguBraTarget
);

	logic [`EX_VADDR_W-1:0] scaledIdx;
	logic jumboQ;

	// Index scaled by 1, 2, 4 or 8
	assign scaledIdx = regValRt[`EX_VADDR_W-1:0] << scale;
	assign aguAddr = regValRs[`EX_VADDR_W-1:0] + scaledIdx;

	always_ff @(posedge clock) begin
		if (rst)
			jumboQ <= 1'b0;
		else
			jumboQ <= srJumbo;
	end

	// Without jumbo mode branches stay inside the current 4GB region
	always_comb begin
		aguBraTarget = aguAddr;
		if (!jumboQ)
			aguBraTarget[`EX_VADDR_W-1:32] = regValPc[`EX_VADDR_W-1:32];
	end

endmodule

`default_nettype wire

/* verilog/exExecute.sv */
//----------------------------------------------------------------------
// Processing part of EX1. Decodes the gated micro-command into a
// register result, branch, memory kind, SR/LR updates and trap code.
// Purely combinational; exWriteback turns these into port values.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exExecute (
	input  exStagePkg::uCmd          gatedCmd,
	input  logic [5:0]               opUIxt,
	input  logic [`EX_DATA_W-1:0]    regValRs,
	input  logic [`EX_DATA_W-1:0]    regValRt,
	input  logic [`EX_DATA_W-1:0]    regValPc,
	input  logic [`EX_DATA_W-1:0]    regInSr,
	input  logic [`EX_DATA_W-1:0]    regInLr,
	input  logic [`EX_GPR_ID_W-1:0]  regIdRm,
	input  logic [1:0]               opPreBra,
	input  logic [`EX_VADDR_W-1:0]   aguAddr,
	input  logic [`EX_VADDR_W-1:0]   aguBraTarget,
	output logic                     doOut,
	output logic [`EX_DATA_W-1:0]    outVal,
	output logic                     doBra,
	output logic [`EX_DATA_W-1:0]    braVal,
	output exStagePkg::memKind       memKindSel,
	output logic                     holdReq,
	output logic                     heldReq,
	output logic [`EX_DATA_W-1:0]    srNext,
	output logic [`EX_DATA_W-1:0]    lrNext,
	output logic [15:0]              trapCode
);

	localparam int HI_W = `EX_DATA_W - `EX_VADDR_W;

	logic [`EX_DATA_W-1:0] braTarget;	// PC-relative target
	logic [`EX_DATA_W-1:0] jmpTarget;	// Register target

	assign braTarget = {regValPc[`EX_DATA_W-1:`EX_VADDR_W], aguBraTarget};
	assign jmpTarget = {regValPc[`EX_DATA_W-1:`EX_VADDR_W], regValRs[`EX_VADDR_W-1:0]};

	always_comb begin
		doOut      = 1'b0;
		outVal     = '0;
		doBra      = 1'b0;
		braVal     = regValPc;
		memKindSel = exStagePkg::MEM_READY;
		holdReq    = 1'b0;
		heldReq    = 1'b0;
		srNext     = regInSr;
		lrNext     = regInLr;
		trapCode   = '0;

		case (gatedCmd)
			exStagePkg::UCMD_NOP: begin
			end
			exStagePkg::UCMD_LEA_MR: begin
				doOut  = 1'b1;
				outVal = {{HI_W{1'b0}}, aguAddr};
			end
			exStagePkg::UCMD_MOV_RM: memKindSel = exStagePkg::MEM_STORE;
			exStagePkg::UCMD_MOV_MR: begin
				memKindSel = exStagePkg::MEM_LOAD;
				heldReq    = 1'b1;		// Result arrives in a later stage
			end
			exStagePkg::UCMD_ALU3: heldReq = 1'b1;
			exStagePkg::UCMD_MOV_IR: begin
				doOut  = 1'b1;
				outVal = regValRt;
				case (opUIxt[3:0])
					4'h0: ;											// Plain immediate
					4'h1: outVal = {regValRs[55:0], regValRt[7:0]};		// LDISH8
					4'h2: outVal = {regValRs[47:0], regValRt[15:0]};	// LDISH16
					4'h3: outVal = {regValRs[31:0], regValRt[31:0]};	// LDISH32
					default: holdReq = 1'b1;
				endcase
			end
			exStagePkg::UCMD_BRA: begin
				doBra  = (opPreBra != 2'b01);	// 01 means already taken in fetch
				braVal = braTarget;
			end
			exStagePkg::UCMD_BRA_NB: begin
				doBra = (opPreBra != 2'b00);	// Fetch went ahead, fall back to PC
			end
			exStagePkg::UCMD_JMP: begin
				doBra  = (opPreBra != 2'b01);
				braVal = jmpTarget;
			end
			exStagePkg::UCMD_JSR: begin
				doBra  = 1'b1;
				braVal = jmpTarget;
				lrNext = regValPc;		// Return address
			end
			exStagePkg::UCMD_OP_IXS: begin
				case (exStagePkg::ixsOp'(opUIxt))
					exStagePkg::IXS_NOP: ;
					exStagePkg::IXS_MOVT: begin
						doOut  = 1'b1;
						outVal = {{(`EX_DATA_W-1){1'b0}}, regInSr[0]};
					end
					exStagePkg::IXS_MOVNT: begin
						doOut  = 1'b1;
						outVal = {{(`EX_DATA_W-1){1'b0}}, !regInSr[0]};
					end
					exStagePkg::IXS_MOVST: begin
						doOut  = 1'b1;
						outVal = {{(`EX_DATA_W-2){1'b0}}, regInSr[1:0]};
					end
					default: holdReq = 1'b1;
				endcase
			end
			exStagePkg::UCMD_OP_IXT: begin
				case (exStagePkg::ixtOp'(opUIxt))
					exStagePkg::IXT_NOP: ;
					exStagePkg::IXT_CLRT: srNext[0] = 1'b0;
					exStagePkg::IXT_SETT: srNext[0] = 1'b1;
					exStagePkg::IXT_CLRS: srNext[1] = 1'b0;
					exStagePkg::IXT_SETS: srNext[1] = 1'b1;
					exStagePkg::IXT_NOTT: srNext[0] = !regInSr[0];
					exStagePkg::IXT_NOTS: srNext[1] = !regInSr[1];
					exStagePkg::IXT_TRAPA: trapCode = {`EX_TRAPA_BASE, regIdRm[3:0]};
					exStagePkg::IXT_BREAK: holdReq = 1'b1;		// Freeze until debugger acts
					default: holdReq = 1'b1;
				endcase
			end
			default: holdReq = 1'b1;		// INVOP and unknown commands
		endcase
	end

endmodule

`default_nettype wire

/* verilog/exWriteback.sv */
//----------------------------------------------------------------------
// Output side of EX1. Steers the result and branch to destination IDs,
// builds the memory request and combines the stall sources.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exWriteback (
	input  logic                     squash,
	input  logic                     doOut,
	input  logic                     doBra,
	input  logic                     holdReq,
	input  logic                     heldReq,
	input  logic [`EX_DATA_W-1:0]    outVal,
	input  logic [`EX_DATA_W-1:0]    braVal,
	input  exStagePkg::memKind       memKindSel,
	input  logic [5:0]               opUIxt,
	input  logic [1:0]               memDataOK,
	input  logic [`EX_GPR_ID_W-1:0]  regIdRm,
	input  logic [`EX_VADDR_W-1:0]   aguAddr,
	input  logic [`EX_DATA_W-1:0]    regValRm,
	input  logic [`EX_DATA_W-1:0]    regValRt,
	input  logic [`EX_DATA_W-1:0]    srNext,
	input  logic [`EX_DATA_W-1:0]    lrNext,
	input  logic [15:0]              trapCode,
	output logic [`EX_GPR_ID_W-1:0]  regIdRn1,
	output logic [`EX_DATA_W-1:0]    regValRn1,
	output logic [`EX_GPR_ID_W-1:0]  regIdCn1,
	output logic [`EX_DATA_W-1:0]    regValCn1,
	output logic [`EX_GPR_ID_W-1:0]  heldIdRn1,
	output logic [`EX_DATA_W-1:0]    regOutSr,
	output logic [`EX_DATA_W-1:0]    regOutLr,
	output logic [`EX_VADDR_W-1:0]   memAddr,
	output logic [4:0]               memOpm,
	output logic [`EX_DATA_W-1:0]    memDataOut,
	output logic [`EX_DATA_W-1:0]    memDataOutB,
	output logic [1:0]               exHold,
	output logic [15:0]              exTrapExc
);

	logic memReq;
	logic memHold;

	assign memReq  = (memKindSel != exStagePkg::MEM_READY);
	assign memHold = memReq && (memDataOK == `EX_HOLD_CODE);

	// Flush kills both writebacks
	assign regIdRn1  = (doOut && !squash) ? regIdRm : `EX_GR_ZZR;
	assign regValRn1 = outVal;
	assign regIdCn1  = (doBra && !squash) ? `EX_CR_PC : `EX_CR_ZZR;
	assign regValCn1 = braVal;
	assign heldIdRn1 = heldReq ? regIdRm : `EX_GR_ZZR;

	assign regOutSr = srNext;
	assign regOutLr = lrNext;

	// Opcode is kind, size bit, then access-width bits
	assign memAddr     = aguAddr;
	assign memOpm      = memReq ? {memKindSel, opUIxt[2], opUIxt[5:4]} : 5'b00000;
	assign memDataOut  = regValRm;
	assign memDataOutB = regValRt;

	assign exHold    = {heldReq, holdReq | memHold};
	assign exTrapExc = trapCode;

endmodule

`default_nettype wire

/* verilog/exStage.sv */
//----------------------------------------------------------------------
// EX1 execute stage top level. Combinational from command to outputs;
// the only flop is the jumbo flag inside the address unit.
// Instantiate once per pipeline, driven by the decode/register stage.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exStage (
	input  logic                     clock,
	input  logic                     rst,
	input  logic [7:0]               opUCmd,
	input  logic [5:0]               opUIxt,
	input  logic                     opBraFlush,
	input  logic [1:0]               opPreBra,
	input  logic [`EX_GPR_ID_W-1:0]  regIdRm,
	input  logic [`EX_DATA_W-1:0]    regValRs,	// Base / source A
	input  logic [`EX_DATA_W-1:0]    regValRt,	// Index / source B
	input  logic [`EX_DATA_W-1:0]    regValRm,	// Store data
	input  logic [`EX_DATA_W-1:0]    regValPc,
	input  logic [`EX_DATA_W-1:0]    regInSr,
	input  logic [`EX_DATA_W-1:0]    regInLr,
	input  logic [1:0]               memDataOK,
	output logic [7:0]               opUCmdOut,
	output logic [`EX_GPR_ID_W-1:0]  regIdRn1,
	output logic [`EX_DATA_W-1:0]    regValRn1,
	output logic [`EX_GPR_ID_W-1:0]  regIdCn1,
	output logic [`EX_DATA_W-1:0]    regValCn1,
	output logic [`EX_GPR_ID_W-1:0]  heldIdRn1,
	output logic [`EX_DATA_W-1:0]    regOutSr,
	output logic [`EX_DATA_W-1:0]    regOutLr,
	output logic [`EX_VADDR_W-1:0]   memAddr,
	output logic [4:0]               memOpm,
	output logic [`EX_DATA_W-1:0]    memDataOut,
	output logic [`EX_DATA_W-1:0]    memDataOutB,
	output logic [1:0]               exHold,
	output logic [15:0]              exTrapExc
);

	exStagePkg::uCmd gatedCmd;
	exStagePkg::memKind memKindSel;
	logic squash, doOut, doBra, holdReq, heldReq;
	logic [`EX_DATA_W-1:0] outVal, braVal, srNext, lrNext;
	logic [`EX_VADDR_W-1:0] aguAddr, aguBraTarget;
	logic [15:0] trapCode;

	exCondGate uCondGate (.opUCmd(opUCmd), .opBraFlush(opBraFlush), .srT(regInSr[0]),
		.gatedCmd(gatedCmd), .squash(squash), .opUCmdOut(opUCmdOut));

	exAgu uAgu (.clock(clock), .rst(rst), .regValRs(regValRs), .regValRt(regValRt),
		.scale(opUIxt[1:0]), .regValPc(regValPc), .srJumbo(regInSr[31]),
		.aguAddr(aguAddr), .aguBraTarget(aguBraTarget));

	exExecute uExecute (.gatedCmd(gatedCmd), .opUIxt(opUIxt), .regValRs(regValRs),
		.regValRt(regValRt), .regValPc(regValPc), .regInSr(regInSr), .regInLr(regInLr),
		.regIdRm(regIdRm), .opPreBra(opPreBra), .aguAddr(aguAddr),
		.aguBraTarget(aguBraTarget), .doOut(doOut), .outVal(outVal), .doBra(doBra),
		.braVal(braVal), .memKindSel(memKindSel), .holdReq(holdReq), .heldReq(heldReq),
		.srNext(srNext), .lrNext(lrNext), .trapCode(trapCode));

	exWriteback uWriteback (.squash(squash), .doOut(doOut), .doBra(doBra),
		.holdReq(holdReq), .heldReq(heldReq), .outVal(outVal), .braVal(braVal),
		.memKindSel(memKindSel), .opUIxt(opUIxt), .memDataOK(memDataOK),
		.regIdRm(regIdRm), .aguAddr(aguAddr), .regValRm(regValRm), .regValRt(regValRt),
		.srNext(srNext), .lrNext(lrNext), .trapCode(trapCode), .regIdRn1(regIdRn1),
		.regValRn1(regValRn1), .regIdCn1(regIdCn1), .regValCn1(regValCn1),
		.heldIdRn1(heldIdRn1), .regOutSr(regOutSr), .regOutLr(regOutLr),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataOutB(memDataOutB), .exHold(exHold), .exTrapExc(exTrapExc));

endmodule

`default_nettype wire

/* tb/exStage_chk.sv */
//----------------------------------------------------------------------
// Concurrent assertions on the EX1 top level, bound into every
// exStage instance. assertFails counts failures for the testbench.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exStageChk (
	input logic                     clock,
	input logic                     rst,
	input logic                     squash,
	input logic                     holdReq,
	input logic                     doBra,
	input logic [`EX_GPR_ID_W-1:0]  regIdRn1,
	input logic [`EX_GPR_ID_W-1:0]  regIdCn1,
	input logic [4:0]               memOpm,
	input logic [1:0]               exHold,
	input logic [`EX_DATA_W-1:0]    regValCn1,
	input logic [`EX_DATA_W-1:0]    regValPc
);

	int assertFails = 0;

	// A flushed slot writes nothing
	squashNoWrite: assert property (@(posedge clock) disable iff (rst)
		squash |-> (regIdRn1 == `EX_GR_ZZR) && (regIdCn1 == `EX_CR_ZZR))
		else begin
			assertFails++;
			$error("Flushed command still wrote a register");
		end

	// Without a memory request the stall comes from decode alone
	idleHoldSource: assert property (@(posedge clock) disable iff (rst)
		(memOpm == 5'b00000) |-> (exHold[0] == holdReq))
		else begin
			assertFails++;
			$error("Stall raised without a memory request or hold request");
		end

	// PC redirect carries a full 64-bit target in the current region
	pcRedirect: assert property (@(posedge clock) disable iff (rst)
		(regIdCn1 == `EX_CR_PC) |->
			(doBra && !squash && (regValCn1[63:48] == regValPc[63:48])))
		else begin
			assertFails++;
			$error("PC redirect without a valid branch");
		end

endmodule

bind exStage exStageChk uChk (.clock(clock), .rst(rst), .squash(squash),
	.holdReq(holdReq), .doBra(doBra), .regIdRn1(regIdRn1), .regIdCn1(regIdCn1),
	.memOpm(memOpm), .exHold(exHold), .regValCn1(regValCn1), .regValPc(regValPc));

`default_nettype wire

/* tb/exStageTb.sv */
//----------------------------------------------------------------------
// Testbench for the EX1 stage. Drives directed and random commands on
// the falling edge, checks every output against a reference model at
// the rising edge and prints a summary line at the end.
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "exStage_defs.svh"
`default_nettype none

module exStageTb;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int TEST_CYCLES = 450;		// Directed plus random vectors
	localparam int SLACK_CYCLES = 20;

	typedef struct packed {
		logic [7:0] cmdOut;
		logic [5:0] idRn1;
		logic [5:0] idCn1;
		logic [5:0] heldId;
		logic [63:0] valRn1;
		logic [63:0] valCn1;
		logic [63:0] sr;
		logic [63:0] lr;
		logic [47:0] addr;
		logic [4:0] opm;
		logic [1:0] hold;
		logic [15:0] trap;
	} exResult;

	logic clock = 1'b0;
	logic rst, opBraFlush, jumboRef;
	logic [15:0] exTrapExc;
	logic [7:0] opUCmd, opUCmdOut;
	logic [5:0] opUIxt, regIdRm, regIdRn1, regIdCn1, heldIdRn1;
	logic [1:0] opPreBra, memDataOK, exHold;
	logic [63:0] regValRs, regValRt, regValRm, regValPc, regInSr, regInLr;
	logic [63:0] regValRn1, regValCn1, regOutSr, regOutLr, memDataOut, memDataOutB;
	logic [47:0] memAddr;
	logic [4:0] memOpm;
	int checks = 0;
	int valueErrors = 0;

	exStage DUT (.clock(clock), .rst(rst), .opUCmd(opUCmd), .opUIxt(opUIxt),
		.opBraFlush(opBraFlush), .opPreBra(opPreBra), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm), .regValPc(regValPc),
		.regInSr(regInSr), .regInLr(regInLr), .memDataOK(memDataOK), .opUCmdOut(opUCmdOut),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1), .regIdCn1(regIdCn1),
		.regValCn1(regValCn1), .heldIdRn1(heldIdRn1), .regOutSr(regOutSr),
		.regOutLr(regOutLr), .memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataOutB(memDataOutB), .exHold(exHold), .exTrapExc(exTrapExc));

	always #(PERIOD / 2) clock = ~clock;

	// Model of the jumbo flop in the address unit
	always @(posedge clock) begin
		if (rst)
			jumboRef <= 1'b0;
		else
			jumboRef <= regInSr[31];
	end

	function automatic exResult expectedOutputs(input logic [7:0] cmd, input logic [5:0] ixt,
		input logic flush, input logic [1:0] pre, input logic [5:0] rm,
		input logic [63:0] rs, rt, pc, sr, lr, input logic [1:0] ok, input logic jumbo);
		exResult r;
		logic en, doOut, doBra, hold, held;
		logic [5:0] g;
		logic [1:0] kind;
		logic [47:0] tgt;
		logic [15:0] trap;
		case (cmd[7:6])
			2'b00: en = 1'b1;
			2'b01: en = 1'b0;
			2'b10: en = sr[0];
			default: en = !sr[0];
		endcase
		if (en && !flush)
			g = cmd[5:0];
		else if ((cmd[5:0] == exStagePkg::UCMD_BRA) && !flush)
			g = exStagePkg::UCMD_BRA_NB;
		else
			g = exStagePkg::UCMD_NOP;
		r.addr = rs[47:0] + (rt[47:0] << ixt[1:0]);
		tgt = jumbo ? r.addr : {pc[47:32], r.addr[31:0]};
		{doOut, doBra, hold, held, kind, trap} = '0;
		r.valRn1 = '0;
		r.valCn1 = pc;
		r.sr = sr;
		r.lr = lr;
		case (g)
			exStagePkg::UCMD_NOP: ;
			exStagePkg::UCMD_LEA_MR: begin
				doOut = 1'b1;
				r.valRn1 = {16'h0, r.addr};
			end
			exStagePkg::UCMD_MOV_RM: kind = 2'b10;
			exStagePkg::UCMD_MOV_MR: begin
				kind = 2'b01;
				held = 1'b1;
			end
			exStagePkg::UCMD_ALU3: held = 1'b1;
			exStagePkg::UCMD_MOV_IR: begin
				doOut = 1'b1;
				hold = (ixt[3:0] > 4'h3);
				r.valRn1 = rt;
				if (ixt[3:0] inside {4'h1, 4'h2, 4'h3})		// Insert 8, 16 or 32 bits
					r.valRn1 = (rs << (4 << ixt[1:0])) | (rt & ((64'h1 << (4 << ixt[1:0])) - 1));
			end
			exStagePkg::UCMD_BRA: begin
				doBra = (pre != 2'b01);
				r.valCn1 = {pc[63:48], tgt};
			end
			exStagePkg::UCMD_BRA_NB: doBra = (pre != 2'b00);
			exStagePkg::UCMD_JMP, exStagePkg::UCMD_JSR: begin
				doBra = (pre != 2'b01) || (g == exStagePkg::UCMD_JSR);
				r.valCn1 = {pc[63:48], rs[47:0]};
				if (g == exStagePkg::UCMD_JSR)
					r.lr = pc;
			end
			exStagePkg::UCMD_OP_IXS: begin
				doOut = (ixt >= 6'd1) && (ixt <= 6'd3);
				hold = (ixt > 6'd3);
				r.valRn1 = (ixt == 6'd3) ? {62'h0, sr[1:0]} : {63'h0, sr[0] ^ (ixt == 6'd2)};
			end
			exStagePkg::UCMD_OP_IXT: begin
				case (ixt)
					6'd0: ;
					6'd1, 6'd2: r.sr[0] = (ixt == 6'd2);
					6'd3, 6'd4: r.sr[1] = (ixt == 6'd4);
					6'd5: r.sr[0] = !sr[0];
					6'd6: r.sr[1] = !sr[1];
					6'd7: trap = {`EX_TRAPA_BASE, rm[3:0]};
					default: hold = 1'b1;		// BREAK and unknown
				endcase
			end
			default: hold = 1'b1;
		endcase
		r.cmdOut = {2'b00, g};
		r.idRn1 = doOut ? rm : `EX_GR_ZZR;
		r.idCn1 = doBra ? `EX_CR_PC : `EX_CR_ZZR;
		r.heldId = held ? rm : `EX_GR_ZZR;
		r.opm = (kind != 2'b00) ? {kind, ixt[2], ixt[5:4]} : 5'b00000;
		r.hold = {held, hold | ((kind != 2'b00) && (ok == `EX_HOLD_CODE))};
		r.trap = trap;
		return r;
	endfunction

	task automatic compareValue(input string name, input logic [63:0] expv, actv);
		checks++;
		if (actv !== expv) begin
			valueErrors++;
			$display("FAILED at %0t ns: %s expected %h actual %h", $time, name, expv, actv);
		end
	endtask

	always @(posedge clock) begin
		exResult e;
		e = expectedOutputs(opUCmd, opUIxt, opBraFlush, opPreBra, regIdRm, regValRs,
			regValRt, regValPc, regInSr, regInLr, memDataOK, jumboRef);
		compareValue("opUCmdOut", e.cmdOut, opUCmdOut);
		compareValue("regIdRn1", e.idRn1, regIdRn1);
		compareValue("regIdCn1", e.idCn1, regIdCn1);
		compareValue("heldIdRn1", e.heldId, heldIdRn1);
		compareValue("regOutSr", e.sr, regOutSr);
		compareValue("regOutLr", e.lr, regOutLr);
		compareValue("memOpm", e.opm, memOpm);
		compareValue("exHold", e.hold, exHold);
		compareValue("exTrapExc", e.trap, exTrapExc);
		if (e.idRn1 != `EX_GR_ZZR)
			compareValue("regValRn1", e.valRn1, regValRn1);
		if (e.idCn1 != `EX_CR_ZZR)
			compareValue("regValCn1", e.valCn1, regValCn1);
		if (e.opm != 5'b00000)
			compareValue("memAddr", e.addr, memAddr);
		if (e.opm[4:3] == 2'b10) begin		// Store data
			compareValue("memDataOut", regValRm, memDataOut);
			compareValue("memDataOutB", regValRt, memDataOutB);
		end
	end

	task automatic applyVector(input logic [7:0] cmd, input logic [5:0] ixt, input logic flush,
		input logic [1:0] pre, input logic [63:0] sr, input logic [1:0] ok);
		@(negedge clock);
		opUCmd = cmd;
		opUIxt = ixt;
		opBraFlush = flush;
		opPreBra = pre;
		regInSr = sr;
		memDataOK = ok;
		regIdRm = 6'($urandom);
		regValRs = {$urandom, $urandom};
		regValRt = {$urandom, $urandom};
		regValRm = {$urandom, $urandom};
		regValPc = {$urandom, $urandom};
		regInLr = {$urandom, $urandom};
	endtask

	initial begin
		logic [5:0] braCmds [0:2];
		logic [5:0] cmd;
		void'($urandom(49));
		braCmds[0] = exStagePkg::UCMD_BRA;
		braCmds[1] = exStagePkg::UCMD_BRA_NB;
		braCmds[2] = exStagePkg::UCMD_JMP;
		rst = 1'b1;
		{opUCmd, opUIxt, opBraFlush, opPreBra, regIdRm, memDataOK} = '0;
		{regValRs, regValRt, regValRm, regValPc, regInSr, regInLr} = '0;
		repeat (RESET_CYCLES)
			applyVector(8'h00, 6'h00, 1'b0, 2'b00, 64'h0, 2'b00);
		rst = 1'b0;

		// Condition field against T, then flush
		for (int i = 0; i < 12; i++)
			applyVector({i[1:0], exStagePkg::UCMD_BRA}, 6'h00, i >= 8, 2'b00, {63'h0, i[2]}, 2'b00);
		for (int s = 0; s < 4; s++)
			applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_LEA_MR}, 6'(s), 1'b0, 2'b00, 64'h0, 2'b00);
		applyVector(8'h00, 6'h00, 1'b0, 2'b00, 64'h8000_0000, 2'b00);		// Jumbo on
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_BRA}, 6'h1, 1'b0, 2'b00, 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_BRA}, 6'h2, 1'b0, 2'b00, 64'h0, 2'b00);

		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_MOV_MR}, 6'h35, 1'b0, 2'b00, 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_MOV_RM}, 6'h26, 1'b0, 2'b00, 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_MOV_RM}, 6'h13, 1'b0, 2'b00, 64'h0,
			`EX_HOLD_CODE);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_MOV_MR}, 6'h04, 1'b0, 2'b00, 64'h0,
			`EX_HOLD_CODE);

		for (int b = 0; b < 12; b++)
			applyVector({2'b00, braCmds[b / 4]}, 6'h0, 1'b0, 2'(b), 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_JSR}, 6'h0, 1'b0, 2'b01, 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_JSR}, 6'h0, 1'b1, 2'b00, 64'h0, 2'b00);

		// Flag ops, TRAPA and BREAK, then MOVT family
		for (int k = 1; k <= 8; k++)
			applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_OP_IXT}, 6'(k), 1'b0, 2'b00,
				{62'h0, 2'(k)}, 2'b00);
		for (int k = 1; k <= 3; k++)
			applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_OP_IXS}, 6'(k), 1'b0, 2'b00,
				{62'h0, 2'(k + 1)}, 2'b00);
		for (int k = 0; k < 4; k++)
			applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_MOV_IR}, 6'(k), 1'b0, 2'b00, 64'h0, 2'b00);
		applyVector({exStagePkg::CC_AL, exStagePkg::UCMD_INVOP}, 6'h0, 1'b0, 2'b00, 64'h0, 2'b00);

		for (int n = 0; n < 400; n++) begin
			cmd = ($urandom % 8 == 0) ? 6'($urandom) : 6'($urandom % 13);
			applyVector({2'($urandom), cmd}, 6'(($urandom % 4 == 0) ? $urandom : $urandom % 10),
				($urandom % 8 == 0), 2'($urandom), {$urandom, $urandom}, 2'($urandom));
		end

		@(negedge clock);		// Last vector checked on the edge before
		$display("Checks: %0d, value errors: %0d, assertion errors: %0d", checks, valueErrors,
			DUT.uChk.assertFails);
		if ((valueErrors == 0) && (DUT.uChk.assertFails == 0))
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(PERIOD * (RESET_CYCLES + TEST_CYCLES + SLACK_CYCLES));
		$display("Timeout: the run did not reach its end in the expected time");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/exStagePkg.sv
verilog/exCondGate.sv
verilog/exAgu.sv
verilog/exExecute.sv
verilog/exWriteback.sv
verilog/exStage.sv
tb/exStage_chk.sv
tb/exStageTb.sv
